/* logic/pad_overlay_pkg.sv */
/*
 * Shared constants for the DIO pad overlay
 * Pad indices, pad variants, connect masks and APB register map
 */
package pad_overlay_pkg;

  ////////////////////////////////////////
  // Dedicated I/O pads
  ////////////////////////////////////////

  localparam int NDioPads = 21;

  typedef logic [NDioPads-1:0] dio_t; // One bit per dedicated pad

  // USB device pads
  localparam int DioUsbDn       = 0;
  localparam int DioUsbDp       = 1;
  localparam int DioUsbD        = 2;
  localparam int DioUsbSuspend  = 3;
  localparam int DioUsbTxMode   = 4;
  localparam int DioUsbDnPullup = 5;
  localparam int DioUsbDpPullup = 6;
  localparam int DioUsbSe0      = 7;
  localparam int DioUsbSense    = 8;
  // SPI device pads, quad lines 17/18 not pinned out
  localparam int DioSpiSd0      = 15;
  localparam int DioSpiSd1      = 16;
  localparam int DioSpiCsb      = 19;
  localparam int DioSpiSck      = 20;

  // Pads that reach a board pin, the rest are tied off
  localparam dio_t DioConnectMask = 21'h19_8163;

  // USB core signals with no pin on this board
  localparam dio_t DioUsbUnpinnedMask = (dio_t'(1) << DioUsbD)       |
                                        (dio_t'(1) << DioUsbSuspend) |
                                        (dio_t'(1) << DioUsbTxMode)  |
                                        (dio_t'(1) << DioUsbSe0);

  typedef enum logic [1:0] {
    PadBidir     = 2'd0,
    PadInputOnly = 2'd1, // Never drives
    PadTolerant  = 2'd2  // 5V tolerant, drives like bidir
  } pad_variant_e;

  localparam pad_variant_e DioPadVariant [NDioPads] = '{
    DioUsbDn  : PadTolerant,
    DioUsbDp  : PadTolerant,
    DioSpiSd0 : PadBidir,
    DioSpiSd1 : PadBidir,
    DioSpiCsb : PadInputOnly,
    DioSpiSck : PadInputOnly,
    default   : PadBidir
  };

  ////////////////////////////////////////
  // APB register map
  ////////////////////////////////////////

  localparam int ApbAddrW = 4;
  localparam int ApbDataW = 32;

  localparam logic [ApbAddrW-1:0] RegCtrlAddr   = 4'h0; // Bit 0 selects USB PHY
  localparam logic [ApbAddrW-1:0] RegStatusAddr = 4'h4; // Bit 0 live flip state
  localparam logic [ApbAddrW-1:0] RegDioInAddr  = 4'h8; // Core side input vector

endpackage : pad_overlay_pkg

/* logic/apb_if.sv */
/*
 * APB bundle between the board side master and the register block
 * Slave answers with zero wait states
 */
`timescale 1ns/1ps

interface apb_if;
  import pad_overlay_pkg::*;

  logic                psel;
  logic                penable;
  logic                pwrite;
  logic [ApbAddrW-1:0] paddr;
  logic [ApbDataW-1:0] pwdata;
  logic [ApbDataW-1:0] prdata;  // Valid in access cycle
  logic                pready;
  logic                pslverr;

  // Requesting side
  modport master (
    output psel, penable, pwrite, paddr, pwdata,
    input  prdata, pready, pslverr
  );

  // Register block side
  modport slave (
    input  psel, penable, pwrite, paddr, pwdata,
    output prdata, pready, pslverr
  );

endinterface : apb_if

/* logic/uphy_if.sv */
/*
 * Lines to the external differential USB PHY
 * Mux side drives transmit, board side fills receive
 */
`timescale 1ns/1ps

interface uphy_if;

  logic dp_tx;    // Copy of pad DP out
  logic dn_tx;    // Copy of pad DN out
  logic oe_n;     // Active low transmit enable
  logic dppullup;
  logic dp_rx;
  logic dn_rx;
  logic d_rx;     // Differential receiver out
  logic sense;    // VBUS sense

  modport mux (
    output dp_tx, dn_tx, oe_n, dppullup,
    input  dp_rx, dn_rx, d_rx, sense
  );

  modport board (
    input  dp_tx, dn_tx, oe_n, dppullup,
    output dp_rx, dn_rx, d_rx, sense
  );

endinterface : uphy_if

/* logic/pad_cfg_regs.sv */
/*
 * APB register block of the pad overlay
 * CTRL holds the PHY select, STATUS and DIO_IN are read only
 */
`timescale 1ns/1ps

module pad_cfg_regs (
  input  logic                  clk_main_i,
  input  logic                  arst_n_i,
  apb_if.slave                  apb,
  input  logic                  undo_swap_i,
  input  pad_overlay_pkg::dio_t dio_in_i,
  output logic                  use_uphy_o
);
  import pad_overlay_pkg::*;

  logic                access;   // Second cycle of a transfer
  logic                ctrl_we;
  logic                addr_err;
  logic [ApbDataW-1:0] rdata;
  logic                use_uphy_q;

  ////////////////////////////////////////
  // Address decode
  ////////////////////////////////////////

  assign access = apb.psel & apb.penable;

  always_comb begin
    rdata    = '0;
    addr_err = 1'b0;
    unique case (apb.paddr)
      RegCtrlAddr: begin
        rdata[0] = use_uphy_q;
      end
      RegStatusAddr: begin
        rdata[0] = undo_swap_i;  // Live, not latched
        addr_err = apb.pwrite;   // Read only
      end
      RegDioInAddr: begin
        rdata    = ApbDataW'(dio_in_i);
        addr_err = apb.pwrite;   // Read only
      end
      default: begin
        addr_err = 1'b1;         // Unmapped
      end
    endcase
  end

  // No wait states
  assign apb.pready  = access;
  assign apb.pslverr = access & addr_err;
  assign apb.prdata  = (access & ~apb.pwrite) ? rdata : '0;

  ////////////////////////////////////////
  // CTRL register
  ////////////////////////////////////////

  assign ctrl_we = access & apb.pwrite & (apb.paddr == RegCtrlAddr);

  always_ff @(posedge clk_main_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      use_uphy_q <= 1'b0;  // Pads by default
    end else if (ctrl_we) begin
      use_uphy_q <= apb.pwdata[0];
    end
  end

  assign use_uphy_o = use_uphy_q;

  // Handshake sanity
  a_pready_in_access : assert property (
    @(posedge clk_main_i) disable iff (!arst_n_i)
    apb.pready |-> (apb.psel && apb.penable)
  ) else $error("pready outside of access cycle");

  a_pslverr_with_pready : assert property (
    @(posedge clk_main_i) disable iff (!arst_n_i)
    apb.pslverr |-> apb.pready
  ) else $error("pslverr without pready");

  // PHY select only moves after a CTRL write
  a_use_uphy_stable : assert property (
    @(posedge clk_main_i) disable iff (!arst_n_i)
    (use_uphy_q != $past(use_uphy_q)) |-> $past(ctrl_we)
  ) else $error("use_uphy changed without CTRL write");

endmodule : pad_cfg_regs

/* logic/usb_overlay_mux.sv */
/*
 * USB overlay between core DIO vectors and the pad ring
 * Undoes the D+/D- pin flip and selects pads or external PHY for receive
 */
`timescale 1ns/1ps

module usb_overlay_mux (
  input  pad_overlay_pkg::dio_t core_out_i,
  input  pad_overlay_pkg::dio_t core_oe_i,
  output pad_overlay_pkg::dio_t core_in_o,
  output pad_overlay_pkg::dio_t pad_out_o,
  output pad_overlay_pkg::dio_t pad_oe_o,
  input  pad_overlay_pkg::dio_t pad_in_i,
  input  logic                  use_uphy_i,
  output logic                  undo_swap_o,
  uphy_if.mux                   uphy
);
  import pad_overlay_pkg::*;

  logic undo_swap;
  logic dp_rx_sel;  // Receive source after PHY select
  logic dn_rx_sel;
  logic d_rx_sel;

  // Core enables DN pullup only when pins are flipped
  assign undo_swap   = core_oe_i[DioUsbDnPullup];
  assign undo_swap_o = undo_swap;

  ////////////////////////////////////////
  // Transmit side, core to pads
  ////////////////////////////////////////

  always_comb begin
    pad_out_o = core_out_i;  // Non USB pads straight through
    pad_oe_o  = core_oe_i;
    if (undo_swap) begin
      pad_out_o[DioUsbDn]       = core_out_i[DioUsbDp];
      pad_out_o[DioUsbDp]       = core_out_i[DioUsbDn];
      pad_oe_o[DioUsbDn]        = core_oe_i[DioUsbDp];
      pad_oe_o[DioUsbDp]        = core_oe_i[DioUsbDn];
      pad_out_o[DioUsbDnPullup] = core_out_i[DioUsbDpPullup];
      pad_out_o[DioUsbDpPullup] = core_out_i[DioUsbDnPullup];
      pad_oe_o[DioUsbDnPullup]  = core_oe_i[DioUsbDpPullup];
      pad_oe_o[DioUsbDpPullup]  = core_oe_i[DioUsbDnPullup];
      pad_out_o[DioUsbD]        = ~core_out_i[DioUsbD];  // Flipped pair inverts D
    end
  end

  ////////////////////////////////////////
  // Receive side, pads or PHY to core
  ////////////////////////////////////////

  assign dp_rx_sel = use_uphy_i ? uphy.dp_rx : pad_in_i[DioUsbDp];
  assign dn_rx_sel = use_uphy_i ? uphy.dn_rx : pad_in_i[DioUsbDn];
  assign d_rx_sel  = use_uphy_i ? uphy.d_rx  : pad_in_i[DioUsbD];

  always_comb begin
    core_in_o = pad_in_i;  // Pullups and others pass through
    core_in_o[DioUsbDn]    = undo_swap ? dp_rx_sel : dn_rx_sel;
    core_in_o[DioUsbDp]    = undo_swap ? dn_rx_sel : dp_rx_sel;
    core_in_o[DioUsbD]     = d_rx_sel ^ undo_swap;
    core_in_o[DioUsbSense] = use_uphy_i ? uphy.sense : pad_in_i[DioUsbSense];
  end

  // PHY transmit mirrors the unflipped pad view
  assign uphy.dp_tx    = pad_out_o[DioUsbDp];
  assign uphy.dn_tx    = pad_out_o[DioUsbDn];
  assign uphy.oe_n     = ~pad_oe_o[DioUsbDp];
  assign uphy.dppullup = pad_out_o[DioUsbDpPullup] & pad_oe_o[DioUsbDpPullup];

  // Flip undo reaches the DN pin
  always_comb begin
    a_flip_dn : assert (!undo_swap || (pad_out_o[DioUsbDn] == core_out_i[DioUsbDp]))
      else $error("DN pad out does not follow core DP under flip");
  end

endmodule : usb_overlay_mux

/* logic/pad_ring.sv */
/*
 * Dedicated I/O pad ring
 * Ties off unmapped pads and applies the per pad variant
 */
`timescale 1ns/1ps

module pad_ring (
  input  pad_overlay_pkg::dio_t out_i,
  input  pad_overlay_pkg::dio_t oe_i,
  input  pad_overlay_pkg::dio_t pad_in_i,
  output pad_overlay_pkg::dio_t pad_out_o,
  output pad_overlay_pkg::dio_t pad_oe_o,
  output pad_overlay_pkg::dio_t in_o
);
  import pad_overlay_pkg::*;

  dio_t input_only;  // Variant forbids driving
  dio_t drive_en;

  for (genvar i = 0; i < NDioPads; i++) begin : gen_pad
    // Bidir and tolerant pads drive alike
    if (DioPadVariant[i] == PadInputOnly) begin : gen_in_only
      assign input_only[i] = 1'b1;
    end else begin : gen_drive
      assign input_only[i] = 1'b0;
    end
    assign drive_en[i] = DioConnectMask[i] & ~input_only[i];
  end

  assign pad_out_o = out_i;             // Value goes out unchanged
  assign pad_oe_o  = oe_i & drive_en;
  assign in_o      = pad_in_i & DioConnectMask;  // Unmapped pads read 0

  // Input only and unpinned USB pads stay quiet
  always_comb begin
    a_no_drive : assert ((pad_oe_o & (input_only | DioUsbUnpinnedMask)) == '0)
      else $error("oe high on a pad that must not drive");
  end

endmodule : pad_ring

/* logic/pad_overlay_top.sv */
/*
 * Pad side glue of the board wrapper
 * Core DIO vectors in, pad vectors and USB PHY lines out, APB for config
 */
`timescale 1ns/1ps

module pad_overlay_top (
  input  logic                                 clk_main_i,
  input  logic                                 arst_n_i,
  // APB
  input  logic                                 psel_i,
  input  logic                                 penable_i,
  input  logic                                 pwrite_i,
  input  logic [pad_overlay_pkg::ApbAddrW-1:0] paddr_i,
  input  logic [pad_overlay_pkg::ApbDataW-1:0] pwdata_i,
  output logic [pad_overlay_pkg::ApbDataW-1:0] prdata_o,
  output logic                                 pready_o,
  output logic                                 pslverr_o,
  // Core side
  input  pad_overlay_pkg::dio_t                dio_out_i,
  input  pad_overlay_pkg::dio_t                dio_oe_i,
  output pad_overlay_pkg::dio_t                dio_in_o,
  // Pad side
  input  pad_overlay_pkg::dio_t                pad_in_i,
  output pad_overlay_pkg::dio_t                pad_out_o,
  output pad_overlay_pkg::dio_t                pad_oe_o,
  // External USB PHY
  input  logic                                 uphy_dp_rx_i,
  input  logic                                 uphy_dn_rx_i,
  input  logic                                 uphy_d_rx_i,
  input  logic                                 uphy_sense_i,
  output logic                                 uphy_dp_tx_o,
  output logic                                 uphy_dn_tx_o,
  output logic                                 uphy_oe_n_o,
  output logic                                 uphy_dppullup_o
);
  import pad_overlay_pkg::*;

  apb_if  apb_bus ();
  uphy_if uphy_bus ();

  logic undo_swap;
  logic use_uphy;
  dio_t dio_in_core;
  dio_t dio_out_umux;  // Between mux and pad ring
  dio_t dio_oe_umux;
  dio_t dio_in_umux;

  // Board side is the APB master
  assign apb_bus.psel    = psel_i;
  assign apb_bus.penable = penable_i;
  assign apb_bus.pwrite  = pwrite_i;
  assign apb_bus.paddr   = paddr_i;
  assign apb_bus.pwdata  = pwdata_i;
  assign prdata_o        = apb_bus.prdata;
  assign pready_o        = apb_bus.pready;
  assign pslverr_o       = apb_bus.pslverr;

  // PHY pins
  assign uphy_bus.dp_rx  = uphy_dp_rx_i;
  assign uphy_bus.dn_rx  = uphy_dn_rx_i;
  assign uphy_bus.d_rx   = uphy_d_rx_i;
  assign uphy_bus.sense  = uphy_sense_i;
  assign uphy_dp_tx_o    = uphy_bus.dp_tx;
  assign uphy_dn_tx_o    = uphy_bus.dn_tx;
  assign uphy_oe_n_o     = uphy_bus.oe_n;
  assign uphy_dppullup_o = uphy_bus.dppullup;

  assign dio_in_o = dio_in_core;

  pad_cfg_regs i_pad_cfg_regs (
    .clk_main_i  ( clk_main_i      ),
    .arst_n_i    ( arst_n_i        ),
    .apb         ( apb_bus.slave   ),
    .undo_swap_i ( undo_swap       ),
    .dio_in_i    ( dio_in_core     ),
    .use_uphy_o  ( use_uphy        )  // Replaces board switch
  );

  usb_overlay_mux i_usb_overlay_mux (
    .core_out_i  ( dio_out_i       ),
    .core_oe_i   ( dio_oe_i        ),
    .core_in_o   ( dio_in_core     ),
    .pad_out_o   ( dio_out_umux    ),
    .pad_oe_o    ( dio_oe_umux     ),
    .pad_in_i    ( dio_in_umux     ),
    .use_uphy_i  ( use_uphy        ),
    .undo_swap_o ( undo_swap       ),
    .uphy        ( uphy_bus.mux    )
  );

  pad_ring i_pad_ring (
    .out_i       ( dio_out_umux    ),
    .oe_i        ( dio_oe_umux     ),
    .pad_in_i    ( pad_in_i        ),
    .pad_out_o   ( pad_out_o       ),
    .pad_oe_o    ( pad_oe_o        ),
    .in_o        ( dio_in_umux     )
  );

endmodule : pad_overlay_top

/* tb/tb_pad_overlay_top.sv */
/*
 * Self-checking testbench of the pad overlay top level
 * Replays pad vectors and APB transfers from the stimulus file
 */
`timescale 1ns/1ps

module tb_pad_overlay_top;
  import pad_overlay_pkg::*;

  logic                clk_main;
  logic                arst_n;
  logic                psel;
  logic                penable;
  logic                pwrite;
  logic [ApbAddrW-1:0] paddr;
  logic [ApbDataW-1:0] pwdata;
  logic [ApbDataW-1:0] prdata;
  logic                pready;
  logic                pslverr;
  dio_t                dio_out;
  dio_t                dio_oe;
  dio_t                dio_in;
  dio_t                pad_in;
  dio_t                pad_out;
  dio_t                pad_oe;
  logic [3:0]          uphy_rx;  // dp dn d sense
  logic [3:0]          uphy_tx;  // dp dn oe_n dppullup

  int errors = 0;
  int checks = 0;
  int cycles = 0;
  int limit  = 0;  // Set once the file is counted

  //////////////////////////////////////////
  // DUT and clock
  //////////////////////////////////////////

  pad_overlay_top i_pad_overlay_top (
    .clk_main_i      ( clk_main   ),
    .arst_n_i        ( arst_n     ),
    .psel_i          ( psel       ),
    .penable_i       ( penable    ),
    .pwrite_i        ( pwrite     ),
    .paddr_i         ( paddr      ),
    .pwdata_i        ( pwdata     ),
    .prdata_o        ( prdata     ),
    .pready_o        ( pready     ),
    .pslverr_o       ( pslverr    ),
    .dio_out_i       ( dio_out    ),
    .dio_oe_i        ( dio_oe     ),
    .dio_in_o        ( dio_in     ),
    .pad_in_i        ( pad_in     ),
    .pad_out_o       ( pad_out    ),
    .pad_oe_o        ( pad_oe     ),
    .uphy_dp_rx_i    ( uphy_rx[3] ),
    .uphy_dn_rx_i    ( uphy_rx[2] ),
    .uphy_d_rx_i     ( uphy_rx[1] ),
    .uphy_sense_i    ( uphy_rx[0] ),
    .uphy_dp_tx_o    ( uphy_tx[3] ),
    .uphy_dn_tx_o    ( uphy_tx[2] ),
    .uphy_oe_n_o     ( uphy_tx[1] ),
    .uphy_dppullup_o ( uphy_tx[0] )
  );

  always #4 clk_main = ~clk_main;  // 8 ns period

  // Watchdog
  always @(posedge clk_main) begin
    cycles <= cycles + 1;
    if (limit > 0 && cycles >= limit) begin
      $display("Timed out after %0d cycles, stimulus file not finished", cycles);
      $display("Checks %0d, errors %0d", checks, errors);
      $display(">>> FAIL");
      $finish;
    end
  end

  //////////////////////////////////////////
  // Tasks
  //////////////////////////////////////////

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("MISMATCH %s expected %h got %h", name, exp, got);
      errors++;
    end
  endtask

  // One cycle, outputs settle before the falling edge
  task automatic apply_pad_vector(input dio_t out_v, input dio_t oe_v, input dio_t pad_v,
                                  input logic [3:0] rx_v, input dio_t exp_out,
                                  input dio_t exp_oe, input dio_t exp_in,
                                  input logic [3:0] exp_tx);
    @(posedge clk_main);
    psel    <= 1'b0;
    penable <= 1'b0;
    dio_out <= out_v;
    dio_oe  <= oe_v;
    pad_in  <= pad_v;
    uphy_rx <= rx_v;
    @(negedge clk_main);
    check_value("pad_out_o", 32'(pad_out), 32'(exp_out));
    check_value("pad_oe_o", 32'(pad_oe), 32'(exp_oe));
    check_value("dio_in_o", 32'(dio_in), 32'(exp_in));
    check_value("uphy_tx", 32'(uphy_tx), 32'(exp_tx));
  endtask

  // Setup then access cycle, response sampled mid access
  task automatic apb_transfer(input logic write, input logic [ApbAddrW-1:0] addr,
                              input logic [ApbDataW-1:0] data_v, input logic exp_err);
    @(posedge clk_main);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= write;
    paddr   <= addr;
    pwdata  <= write ? data_v : '0;
    @(posedge clk_main);
    penable <= 1'b1;
    @(negedge clk_main);
    check_value("pready_o", 32'(pready), 32'h1);
    check_value("pslverr_o", 32'(pslverr), 32'(exp_err));
    if (!write) begin
      check_value("prdata_o", prdata, data_v);  // Expected read data
    end
  endtask

  //////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////

  initial begin
    int              fd;
    int              n;
    int              nlines;
    logic [7:0]      op;
    logic [8*160-1:0] line;
    logic [31:0]     f_addr;
    logic [31:0]     f_data;
    logic            f_err;
    dio_t            f_out;
    dio_t            f_oe;
    dio_t            f_pad;
    dio_t            e_out;
    dio_t            e_oe;
    dio_t            e_in;
    logic [3:0]      f_rx;
    logic [3:0]      e_tx;

    clk_main = 1'b0;
    arst_n   = 1'b0;
    psel     = 1'b0;
    penable  = 1'b0;
    pwrite   = 1'b0;
    paddr    = '0;
    pwdata   = '0;
    dio_out  = '0;
    dio_oe   = '0;
    pad_in   = '0;
    uphy_rx  = '0;
    nlines   = 0;

    fd = $fopen("tb/pad_overlay_stimulus.txt", "r");
    if (fd == 0) begin
      $display("Could not open the stimulus file");
      $display(">>> FAIL");
      $finish;
    end else begin
      while ($fgets(line, fd) != 0) begin
        nlines++;
      end
      $fclose(fd);
      limit = 3 * nlines + 20;
      fd = $fopen("tb/pad_overlay_stimulus.txt", "r");

      repeat (3) @(posedge clk_main);
      arst_n <= 1'b1;

      while (!$feof(fd)) begin
        n = $fscanf(fd, "%s", op);
        if (n == 1) begin
          if (op == "#") begin
            n = $fgets(line, fd);  // Skip comment text
          end else if (op == "P") begin
            n = $fscanf(fd, "%h %h %h %h %h %h %h %h",
                        f_out, f_oe, f_pad, f_rx, e_out, e_oe, e_in, e_tx);
            apply_pad_vector(f_out, f_oe, f_pad, f_rx, e_out, e_oe, e_in, e_tx);
          end else if (op == "W" || op == "R") begin
            n = $fscanf(fd, "%h %h %h", f_addr, f_data, f_err);
            apb_transfer(op == "W", f_addr[ApbAddrW-1:0], f_data, f_err);
          end else begin
            $display("Unknown operation code in the stimulus file");
            errors++;
          end
        end
      end
      $fclose(fd);

      // Close the last access cycle
      @(posedge clk_main);
      psel    <= 1'b0;
      penable <= 1'b0;
      @(posedge clk_main);

      $display("Checks %0d, errors %0d", checks, errors);
      if (errors == 0) begin
        $display(">>> PASS");
      end else begin
        $display(">>> FAIL");
      end
      $finish;
    end
  end

endmodule : tb_pad_overlay_top

/* all.f */
logic/pad_overlay_pkg.sv
logic/apb_if.sv
logic/uphy_if.sv
logic/pad_cfg_regs.sv
logic/usb_overlay_mux.sv
logic/pad_ring.sv
logic/pad_overlay_top.sv
tb/tb_pad_overlay_top.sv

/* run_sim.sh */
#!/bin/sh
# Compile the pad overlay testbench with Verilator and run it
# Pass or fail comes from the log, not from the exit code of the binary
set -e

cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/1ps -j 0 \
  --top-module tb_pad_overlay_top \
  -f all.f \
  -o sim_pad_overlay

./obj_dir/sim_pad_overlay > sim.log 2>&1 || true
cat sim.log

if grep -q '^>>> PASS$' sim.log; then
  exit 0
else
  exit 1
fi

/* tb/pad_overlay_stimulus.txt */
# P dio_out dio_oe pad_in uphy_rx exp_pad_out exp_pad_oe exp_dio_in exp_uphy_tx
# W addr wdata exp_err / R addr exp_rdata exp_err, uphy_rx = dp dn d sense, uphy_tx = dp dn oe_n pu
# Reset values
P 000000 000000 000000 0 000000 000000 000000 2
R 0 00000000 0
R 4 00000000 0
R 8 00000000 0
# Pad ring, connect mask and input only pads
P 1FFFFF 1FFFDF 1FFFFF 0 1FFFFF 018143 198163 D
P 1FFFFF 1FFFFF 1FFFFF 0 1FFFFB 018163 198167 D
P 000000 000000 067E9C 0 000000 000000 000000 2
R 8 00000000 0
# Flip undo, then straight through
P 000045 000022 000101 0 000022 000041 000106 A
R 4 00000001 0
R 8 00000106 0
P 000045 000002 000101 0 000045 000002 000101 4
R 4 00000000 0
# PHY transmit copy of the pullup
P 000040 000040 000000 0 000040 000040 000000 3
P 000020 000020 000000 0 000044 000040 000004 3
# APB errors with CTRL clear
W 4 00000001 1
W 8 00000001 1
W C 00000001 1
R C 00000000 1
R 0 00000000 0
# PHY receive select, errors must not touch CTRL
W 0 00000001 0
R 0 00000001 0
W 4 00000000 1
W C 00000000 1
R 0 00000001 0
P 000000 000000 000103 A 000000 000000 000006 2
R 8 00000006 0
P 000000 000020 000103 A 000004 000040 000001 2
R 8 00000001 0
R 4 00000001 0
P 000000 000000 000000 5 000000 000000 000101 2
# Back to the pads
W 0 00000000 0
P 000000 000000 000000 5 000000 000000 000000 2
R 0 00000000 0
